// ==== perf_counters.f ====
common/hpm_pkg.sv
src/hpm_event_decode.sv
src/hpm_counter_bank.sv
src/hpm_csr_regs.sv
src/perf_counters.sv
tests/hpm_checker.sv
tests/tb_perf_counters.sv

// ==== tests/tb_perf_counters.sv ====
// Testbench of the performance monitor with random CSR and event stimulus against a shadow model
module tb_perf_counters;
  timeunit 1ns;
  timeprecision 1ps;
  import hpm_pkg::*;

  logic                                clk;
  logic                                rst_n;
  logic                                debug_mode;
  logic [ADDR_W-1:0]                   addr;
  logic                                we;
  logic [DATA_W-1:0]                   wdata;
  logic [DATA_W-1:0]                   rdata;
  commit_instr_t [NR_COMMIT_PORTS-1:0] commit_instr;
  logic [NR_COMMIT_PORTS-1:0]          commit_ack;
  core_events_t                        events;
  logic [DATA_W-1:0]                   inhibit;
  logic [31:0]                         rng;
  int                                  checks;
  int                                  errors;
  int                                  timeouts;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  perf_counters dut (
    .clk_i (clk), .rst_ni (rst_n), .debug_mode_i (debug_mode),
    .addr_i (addr), .we_i (we), .data_i (wdata), .data_o (rdata),
    .commit_instr_i (commit_instr), .commit_ack_i (commit_ack),
    .events_i (events), .mcountinhibit_i (inhibit)
  );

  hpm_checker chk (
    .clk_i (clk), .rst_ni (rst_n), .debug_mode_i (debug_mode),
    .addr_i (addr), .we_i (we), .data_i (wdata), .rdata_i (rdata),
    .commit_instr_i (commit_instr), .commit_ack_i (commit_ack),
    .events_i (events), .mcountinhibit_i (inhibit),
    .checks_o (checks), .errors_o (errors)
  );

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng = xorshift32(rng);
    r = rng;
  endtask

  function automatic logic [ADDR_W-1:0] block_base(int b);
    case (b)
      0:       return CSR_MHPM_COUNTER_BASE;
      1:       return CSR_MHPM_COUNTER_H_BASE;
      2:       return CSR_MHPM_EVENT_BASE;
      3:       return CSR_HPM_COUNTER_BASE;
      default: return CSR_HPM_COUNTER_H_BASE;
    endcase
  endfunction

  // Mapped, just-past-the-end or fully random address
  function automatic logic [ADDR_W-1:0] pick_addr(logic [15:0] x);
    if (x[2:0] < 5) return block_base(x[2:0]) + x[5:3] % 6;
    if (x[2:0] == 5) return block_base(x[8:6] % 5) + 6 + x[10:9];
    return x[15:4];
  endfunction

  // Link registers and x0 show up often
  function automatic logic [REG_W-1:0] pick_rd(logic [5:0] x);
    case (x[1:0])
      2'd0:    return 5'd0;
      2'd1:    return 5'd1;
      2'd2:    return 5'd5;
      default: return {1'b0, x[5:2]};
    endcase
  endfunction

  task automatic set_idle();
    commit_instr = '0;
    commit_ack   = '0;
    events       = '0;
    debug_mode   = 1'b0;
    inhibit      = '0;
    we           = 1'b0;
  endtask

  task automatic csr_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    @(negedge clk);
    addr  = a;
    wdata = d;
    we    = 1'b1;
    @(negedge clk);
    we = 1'b0;
  endtask

  // Sweep every block plus the address past each end
  task automatic read_all();
    for (int b = 0; b < 5; b++) begin
      for (int o = 0; o <= NR_COUNTERS; o++) begin
        @(negedge clk);
        set_idle();
        addr = block_base(b) + o;
      end
    end
  endtask

  task automatic drive_random(input bit with_writes, input bit with_freeze);
    logic [31:0] r0, r1, r2, r3;
    next_rand(r0);
    next_rand(r1);
    next_rand(r2);
    next_rand(r3);
    @(negedge clk);
    for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
      commit_instr[p].fu = fu_e'(r0[3*p +: 3]);
      commit_instr[p].op = op_e'(r0[6+2*p +: 2] % 3);
      commit_instr[p].rd = pick_rd(r0[10+6*p +: 6]);
    end
    commit_ack = r0[23:22];
    events     = core_events_t'(r1[9:0]);
    addr       = pick_addr(r1[31:16]);
    we         = with_writes && (r1[12:10] == 3'd0);
    wdata      = r2;
    debug_mode = with_freeze && (r3[31:28] == 4'd0);
    inhibit    = (with_freeze && r3[27]) ? r3 : '0;
  endtask

  task automatic wait_high(input int k, input logic [DATA_W-1:0] target, input int limit);
    bit hit;
    hit = 1'b0;
    for (int i = 0; i < limit && !hit; i++) begin
      @(posedge clk);
      hit = (rdata === target);
    end
    if (!hit) begin
      timeouts++;
      $display("Timeout: high half of counter %0d never reached %h", k, target);
    end
  endtask

  initial begin
    logic [31:0] r;
    rng      = 32'h1e69_d90a;
    timeouts = 0;
    set_idle();
    addr  = '0;
    wdata = '0;
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    read_all();  // Everything zero after reset
    for (int k = 0; k < NR_COUNTERS; k++) begin
      next_rand(r);
      csr_write(CSR_MHPM_EVENT_BASE + k, r);
    end
    read_all();

    // Rotate every 5-bit code through the selectors
    for (int round = 0; round < 6; round++) begin
      for (int k = 0; k < NR_COUNTERS; k++) begin
        csr_write(CSR_MHPM_EVENT_BASE + k, round * NR_COUNTERS + k);
      end
      repeat (80) drive_random(1'b0, 1'b0);
      read_all();
    end

    // Frequent events on every counter before the freeze mix
    for (int k = 0; k < NR_COUNTERS; k++) begin
      csr_write(CSR_MHPM_EVENT_BASE + k, EV_ICACHE_MISS + k);
    end
    repeat (400) drive_random(1'b1, 1'b1);  // Inhibit, debug and write freezes
    read_all();

    // ----------------------------------------
    // Carry from low into high half
    // ----------------------------------------
    for (int k = 0; k < NR_COUNTERS; k++) begin
      next_rand(r);
      csr_write(CSR_MHPM_EVENT_BASE + k, EV_STALL);
      csr_write(CSR_MHPM_COUNTER_H_BASE + k, r);
      csr_write(CSR_MHPM_COUNTER_BASE + k, 32'hFFFF_FFFF);
      @(negedge clk);
      set_idle();
      events.stall_issue = 1'b1;
      addr = CSR_MHPM_COUNTER_H_BASE + k;
      wait_high(k, r + 1, 20);
      next_rand(r);
      csr_write(CSR_MHPM_COUNTER_H_BASE + k, r);  // Low half must survive
      next_rand(r);
      csr_write(CSR_MHPM_COUNTER_BASE + k, r);
      read_all();
    end

    // Mirror and unmapped writes leave state alone
    for (int k = 0; k < NR_COUNTERS; k++) begin
      next_rand(r);
      csr_write(CSR_HPM_COUNTER_BASE + k, r);
      csr_write(CSR_HPM_COUNTER_H_BASE + k, ~r);
      csr_write(block_base(k % 5) + NR_COUNTERS, r);
    end
    read_all();

    @(negedge clk);
    $display("Checks %0d, data errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0 && checks > 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/hpm_checker.sv ====
// Performance monitor checker, shadow model of counters and selectors with read-data compare
module hpm_checker (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic                                                  debug_mode_i,
  input  logic [hpm_pkg::ADDR_W-1:0]                            addr_i,
  input  logic                                                  we_i,
  input  logic [hpm_pkg::DATA_W-1:0]                            data_i,
  input  logic [hpm_pkg::DATA_W-1:0]                            rdata_i,  // DUT data_o
  input  hpm_pkg::commit_instr_t [hpm_pkg::NR_COMMIT_PORTS-1:0] commit_instr_i,
  input  logic                   [hpm_pkg::NR_COMMIT_PORTS-1:0] commit_ack_i,
  input  hpm_pkg::core_events_t                                 events_i,
  input  logic [hpm_pkg::DATA_W-1:0]                            mcountinhibit_i,
  output int                                                    checks_o,
  output int                                                    errors_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import hpm_pkg::*;

  logic [CNT_W-1:0] cnt_m [NR_COUNTERS];
  logic [EV_W-1:0]  sel_m [NR_COUNTERS];

  // Offset into a six-entry CSR block, -1 when outside
  function automatic int block_off(logic [ADDR_W-1:0] addr, logic [ADDR_W-1:0] base);
    logic [ADDR_W-1:0] off;
    off = addr - base;
    return (off < NR_COUNTERS) ? int'(off) : -1;
  endfunction

  // Expected read data for an address
  function automatic logic [DATA_W-1:0] expected_read(logic [ADDR_W-1:0] addr);
    int o;
    o = block_off(addr, CSR_MHPM_COUNTER_BASE);
    if (o < 0) o = block_off(addr, CSR_HPM_COUNTER_BASE);  // User mirror
    if (o >= 0) return cnt_m[o][DATA_W-1:0];
    o = block_off(addr, CSR_MHPM_COUNTER_H_BASE);
    if (o < 0) o = block_off(addr, CSR_HPM_COUNTER_H_BASE);
    if (o >= 0) return cnt_m[o][CNT_W-1:DATA_W];
    o = block_off(addr, CSR_MHPM_EVENT_BASE);
    if (o >= 0) return DATA_W'(sel_m[o]);
    return '0;
  endfunction

  // Whether an event code fires in the current cycle
  function automatic logic event_fires(logic [EV_W-1:0] code);
    logic ld, st, br, call, ret, int_op, fp;
    commit_instr_t c;
    {ld, st, br, call, ret, int_op, fp} = '0;
    for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
      c = commit_instr_i[p];
      if (commit_ack_i[p]) begin
        ld     |= c.fu == FU_LOAD;
        st     |= c.fu == FU_STORE;
        br     |= c.fu == FU_CTRL_FLOW;
        call   |= c.fu == FU_CTRL_FLOW && (c.op == OP_ADD || c.op == OP_JALR) &&
                  (c.rd == 5'd1 || c.rd == 5'd5);
        ret    |= c.op == OP_JALR && c.rd == 5'd0;
        int_op |= c.fu == FU_ALU || c.fu == FU_MULT;
        fp     |= c.fu == FU_FPU || c.fu == FU_FPU_VEC;
      end
    end
    case (code)
      EV_ICACHE_MISS: return events_i.icache_miss;
      EV_DCACHE_MISS: return events_i.dcache_miss;
      EV_ITLB_MISS:   return events_i.itlb_miss;
      EV_DTLB_MISS:   return events_i.dtlb_miss;
      EV_LOAD:        return ld;
      EV_STORE:       return st;
      EV_EXCEPTION:   return events_i.exception;
      EV_ERET:        return events_i.eret;
      EV_BRANCH:      return br;
      EV_MISPREDICT:  return events_i.mispredict;
      EV_CALL:        return call;
      EV_RETURN:      return ret;
      EV_SB_FULL:     return events_i.sb_full;
      EV_IF_EMPTY:    return events_i.if_empty;
      EV_INT:         return int_op;
      EV_FP:          return fp;
      EV_STALL:       return events_i.stall_issue;
      default:        return 1'b0;
    endcase
  endfunction

  initial begin
    checks_o = 0;
    errors_o = 0;
  end

  // ----------------------------------------
  // Compare, then advance the model
  // ----------------------------------------
  always @(posedge clk_i or negedge rst_ni) begin
    logic [DATA_W-1:0] exp;
    int o;
    if (!rst_ni) begin
      for (int k = 0; k < NR_COUNTERS; k++) begin
        cnt_m[k] = '0;
        sel_m[k] = '0;
      end
    end else begin
      exp = expected_read(addr_i);
      checks_o++;
      if (rdata_i !== exp) begin
        errors_o++;
        $display("FAIL data_o addr=%h expected=%h actual=%h", addr_i, exp, rdata_i);
      end
      for (int k = 0; k < NR_COUNTERS; k++) begin
        if (!we_i && !debug_mode_i && !mcountinhibit_i[INHIBIT_BASE + k] &&
            event_fires(sel_m[k])) begin
          cnt_m[k] = cnt_m[k] + 1;
        end
      end
      if (we_i) begin  // Mirrors and unmapped addresses fall through
        o = block_off(addr_i, CSR_MHPM_COUNTER_BASE);
        if (o >= 0) cnt_m[o][DATA_W-1:0] = data_i;
        o = block_off(addr_i, CSR_MHPM_COUNTER_H_BASE);
        if (o >= 0) cnt_m[o][CNT_W-1:DATA_W] = data_i;
        o = block_off(addr_i, CSR_MHPM_EVENT_BASE);
        if (o >= 0) sel_m[o] = data_i[EV_W-1:0];
      end
    end
  end

endmodule

// ==== src/perf_counters.sv ====
// Performance monitor top, event decode feeding the counter bank behind a CSR file
module perf_counters (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic                                                  debug_mode_i,
  // SRAM-like CSR port
  input  logic [hpm_pkg::ADDR_W-1:0]                            addr_i,
  input  logic                                                  we_i,
  input  logic [hpm_pkg::DATA_W-1:0]                            data_i,
  output logic [hpm_pkg::DATA_W-1:0]                            data_o,
  // Commit stage
  input  hpm_pkg::commit_instr_t [hpm_pkg::NR_COMMIT_PORTS-1:0] commit_instr_i,
  input  logic                   [hpm_pkg::NR_COMMIT_PORTS-1:0] commit_ack_i,
  // Core event pulses and inhibit mask
  input  hpm_pkg::core_events_t                                 events_i,
  input  logic [hpm_pkg::DATA_W-1:0]                            mcountinhibit_i
);
  import hpm_pkg::*;

  hpm_event_e [NR_COUNTERS-1:0]      event_sel;
  cnt_wr_t                           cnt_wr;
  logic [NR_COUNTERS-1:0]            inc;
  logic [NR_COUNTERS-1:0][CNT_W-1:0] counters;

  hpm_event_decode i_event_decode (
    .commit_instr_i (commit_instr_i),
    .commit_ack_i   (commit_ack_i),
    .events_i       (events_i),
    .event_sel_i    (event_sel),
    .inc_o          (inc)
  );

  hpm_counter_bank i_counter_bank (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .debug_mode_i    (debug_mode_i),
    .mcountinhibit_i (mcountinhibit_i),
    .inc_i           (inc),
    .cnt_wr_i        (cnt_wr),
    .counters_o      (counters)
  );

  hpm_csr_regs i_csr_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .addr_i      (addr_i),
    .we_i        (we_i),
    .data_i      (data_i),
    .counters_i  (counters),
    .event_sel_o (event_sel),
    .cnt_wr_o    (cnt_wr),
    .data_o      (data_o)
  );

endmodule

// ==== src/hpm_csr_regs.sv ====
// CSR file of the monitor, address decode, event selectors, read mux and counter writes
module hpm_csr_regs (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  input  logic [hpm_pkg::ADDR_W-1:0]                         addr_i,
  input  logic                                               we_i,
  input  logic [hpm_pkg::DATA_W-1:0]                         data_i,
  input  logic [hpm_pkg::NR_COUNTERS-1:0][hpm_pkg::CNT_W-1:0] counters_i,
  output hpm_pkg::hpm_event_e [hpm_pkg::NR_COUNTERS-1:0]      event_sel_o,
  output hpm_pkg::cnt_wr_t                                    cnt_wr_o,
  output logic [hpm_pkg::DATA_W-1:0]                         data_o
);
  import hpm_pkg::*;

  csr_kind_e                        kind;
  logic [ADDR_W-1:0]                base;  // First address of the hit block
  logic [IDX_W-1:0]                 idx;
  hpm_event_e [NR_COUNTERS-1:0]     event_sel_q;

  // True when addr falls in the six-entry block starting at blk
  function automatic logic in_block(logic [ADDR_W-1:0] addr, logic [ADDR_W-1:0] blk);
    return (addr >= blk) && (addr < blk + NR_COUNTERS);
  endfunction

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  always_comb begin
    kind = CSR_NONE;
    base = '0;
    if (in_block(addr_i, CSR_MHPM_COUNTER_BASE)) begin
      kind = CSR_CNT_LO;
      base = CSR_MHPM_COUNTER_BASE;
    end else if (in_block(addr_i, CSR_MHPM_COUNTER_H_BASE)) begin
      kind = CSR_CNT_HI;
      base = CSR_MHPM_COUNTER_H_BASE;
    end else if (in_block(addr_i, CSR_MHPM_EVENT_BASE)) begin
      kind = CSR_EVT_SEL;
      base = CSR_MHPM_EVENT_BASE;
    end else if (in_block(addr_i, CSR_HPM_COUNTER_BASE)) begin
      kind = CSR_UCNT_LO;
      base = CSR_HPM_COUNTER_BASE;
    end else if (in_block(addr_i, CSR_HPM_COUNTER_H_BASE)) begin
      kind = CSR_UCNT_HI;
      base = CSR_HPM_COUNTER_H_BASE;
    end
    idx = IDX_W'(addr_i - base);  // Only meaningful on a hit
  end

  // ----------------------------------------
  // Read mux
  // ----------------------------------------
  always_comb begin
    case (kind)
      CSR_CNT_LO, CSR_UCNT_LO: data_o = counters_i[idx][DATA_W-1:0];
      CSR_CNT_HI, CSR_UCNT_HI: data_o = counters_i[idx][CNT_W-1:DATA_W];
      CSR_EVT_SEL:             data_o = DATA_W'(event_sel_q[idx]);
      default:                 data_o = '0;
    endcase
  end

  // Mirrors and unmapped writes still stall counting for the cycle
  assign cnt_wr_o.csr_we = we_i;
  assign cnt_wr_o.lo_we  = we_i && (kind == CSR_CNT_LO);
  assign cnt_wr_o.hi_we  = we_i && (kind == CSR_CNT_HI);
  assign cnt_wr_o.idx    = idx;
  assign cnt_wr_o.wdata  = data_i;

  // Event selectors keep only the low bits of the write data
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int k = 0; k < NR_COUNTERS; k++) begin
        event_sel_q[k] <= EV_NONE;
      end
    end else if (we_i && (kind == CSR_EVT_SEL)) begin
      event_sel_q[idx] <= hpm_event_e'(data_i[EV_W-1:0]);
    end
  end

  assign event_sel_o = event_sel_q;

endmodule

// ==== src/hpm_counter_bank.sv ====
// Counter bank, six 64-bit event counters with gated increment and half-word writes
module hpm_counter_bank (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  input  logic                                               debug_mode_i,
  input  logic [hpm_pkg::DATA_W-1:0]                         mcountinhibit_i,
  input  logic [hpm_pkg::NR_COUNTERS-1:0]                    inc_i,
  input  hpm_pkg::cnt_wr_t                                   cnt_wr_i,
  output logic [hpm_pkg::NR_COUNTERS-1:0][hpm_pkg::CNT_W-1:0] counters_o
);
  import hpm_pkg::*;

  logic [NR_COUNTERS-1:0]            cnt_en;
  logic [NR_COUNTERS-1:0][CNT_W-1:0] cnt_d;
  logic [NR_COUNTERS-1:0][CNT_W-1:0] cnt_q;

  // ----------------------------------------
  // Increment gating
  // ----------------------------------------
  // Counting pauses in debug mode and during any CSR write cycle
  always_comb begin
    for (int k = 0; k < NR_COUNTERS; k++) begin
      cnt_en[k] = inc_i[k] && !mcountinhibit_i[INHIBIT_BASE + k] &&
                  !debug_mode_i && !cnt_wr_i.csr_we;
    end
  end

  // ----------------------------------------
  // Next-state
  // ----------------------------------------
  always_comb begin
    cnt_d = cnt_q;
    for (int k = 0; k < NR_COUNTERS; k++) begin
      if (cnt_en[k]) begin
        cnt_d[k] = cnt_q[k] + CNT_W'(1);
      end
      if (cnt_wr_i.idx == IDX_W'(k)) begin
        if (cnt_wr_i.lo_we) begin
          cnt_d[k][DATA_W-1:0] = cnt_wr_i.wdata;  // High half kept
        end
        if (cnt_wr_i.hi_we) begin
          cnt_d[k][CNT_W-1:DATA_W] = cnt_wr_i.wdata;  // Low half kept
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign counters_o = cnt_q;

endmodule

// ==== src/hpm_event_decode.sv ====
// Event decode, classifies committed instructions and picks one event per counter
module hpm_event_decode (
  input  hpm_pkg::commit_instr_t [hpm_pkg::NR_COMMIT_PORTS-1:0] commit_instr_i,
  input  logic                   [hpm_pkg::NR_COMMIT_PORTS-1:0] commit_ack_i,
  input  hpm_pkg::core_events_t                                 events_i,
  input  hpm_pkg::hpm_event_e    [hpm_pkg::NR_COUNTERS-1:0]     event_sel_i,
  output logic                   [hpm_pkg::NR_COUNTERS-1:0]     inc_o
);
  import hpm_pkg::*;

  // Commit-class flags, ORed over acknowledged ports
  logic load_any;
  logic store_any;
  logic branch_any;
  logic call_any;
  logic return_any;
  logic int_any;
  logic fp_any;

  // ----------------------------------------
  // Commit classification
  // ----------------------------------------
  always_comb begin
    load_any   = 1'b0;
    store_any  = 1'b0;
    branch_any = 1'b0;
    call_any   = 1'b0;
    return_any = 1'b0;
    int_any    = 1'b0;
    fp_any     = 1'b0;
    for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
      if (commit_ack_i[p]) begin
        load_any   |= commit_instr_i[p].fu == FU_LOAD;
        store_any  |= commit_instr_i[p].fu == FU_STORE;
        branch_any |= commit_instr_i[p].fu == FU_CTRL_FLOW;
        // JAL decodes as ADD, link register marks a call
        call_any   |= (commit_instr_i[p].fu == FU_CTRL_FLOW) &&
                      (commit_instr_i[p].op inside {OP_ADD, OP_JALR}) &&
                      (commit_instr_i[p].rd inside {RA_REG, ALT_RA_REG});
        return_any |= (commit_instr_i[p].op == OP_JALR) && (commit_instr_i[p].rd == '0);
        int_any    |= commit_instr_i[p].fu inside {FU_ALU, FU_MULT};
        fp_any     |= commit_instr_i[p].fu inside {FU_FPU, FU_FPU_VEC};
      end
    end
  end

  // ----------------------------------------
  // Per-counter event mux
  // ----------------------------------------
  always_comb begin
    for (int k = 0; k < NR_COUNTERS; k++) begin
      case (event_sel_i[k])
        EV_ICACHE_MISS: inc_o[k] = events_i.icache_miss;
        EV_DCACHE_MISS: inc_o[k] = events_i.dcache_miss;
        EV_ITLB_MISS:   inc_o[k] = events_i.itlb_miss;
        EV_DTLB_MISS:   inc_o[k] = events_i.dtlb_miss;
        EV_LOAD:        inc_o[k] = load_any;
        EV_STORE:       inc_o[k] = store_any;
        EV_EXCEPTION:   inc_o[k] = events_i.exception;
        EV_ERET:        inc_o[k] = events_i.eret;
        EV_BRANCH:      inc_o[k] = branch_any;
        EV_MISPREDICT:  inc_o[k] = events_i.mispredict;
        EV_CALL:        inc_o[k] = call_any;
        EV_RETURN:      inc_o[k] = return_any;
        EV_SB_FULL:     inc_o[k] = events_i.sb_full;
        EV_IF_EMPTY:    inc_o[k] = events_i.if_empty;
        EV_INT:         inc_o[k] = int_any;
        EV_FP:          inc_o[k] = fp_any;
        EV_STALL:       inc_o[k] = events_i.stall_issue;
        default:        inc_o[k] = 1'b0;  // EV_NONE and unused codes
      endcase
    end
  end

endmodule

// ==== common/hpm_pkg.sv ====
// Hardware performance monitor shared widths, CSR map, event codes and bus types
package hpm_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------
  localparam int unsigned NR_COUNTERS     = 6;
  localparam int unsigned NR_COMMIT_PORTS = 2;
  localparam int unsigned CNT_W           = 64;
  localparam int unsigned DATA_W          = 32;
  localparam int unsigned ADDR_W          = 12;
  localparam int unsigned EV_W            = 5;   // Event selector field
  localparam int unsigned REG_W           = 5;   // Architectural register index
  localparam int unsigned IDX_W           = $clog2(NR_COUNTERS);
  localparam int unsigned INHIBIT_BASE    = 3;   // mcountinhibit bit of mhpmcounter3

  // ----------------------------------------
  // CSR map, six addresses per block
  // ----------------------------------------
  localparam logic [ADDR_W-1:0] CSR_MHPM_COUNTER_BASE   = 12'hB03;
  localparam logic [ADDR_W-1:0] CSR_MHPM_COUNTER_H_BASE = 12'hB83;
  localparam logic [ADDR_W-1:0] CSR_MHPM_EVENT_BASE     = 12'h323;
  localparam logic [ADDR_W-1:0] CSR_HPM_COUNTER_BASE    = 12'hC03;  // User mirrors
  localparam logic [ADDR_W-1:0] CSR_HPM_COUNTER_H_BASE  = 12'hC83;

  // Link registers of the calling convention
  localparam logic [REG_W-1:0] RA_REG     = 5'd1;
  localparam logic [REG_W-1:0] ALT_RA_REG = 5'd5;

  // Event codes, gaps are codes that count nothing
  typedef enum logic [EV_W-1:0] {
    EV_NONE        = 5'd0,
    EV_ICACHE_MISS = 5'd1,
    EV_DCACHE_MISS = 5'd2,
    EV_ITLB_MISS   = 5'd3,
    EV_DTLB_MISS   = 5'd4,
    EV_LOAD        = 5'd5,
    EV_STORE       = 5'd6,
    EV_EXCEPTION   = 5'd7,
    EV_ERET        = 5'd8,
    EV_BRANCH      = 5'd9,
    EV_MISPREDICT  = 5'd10,
    EV_CALL        = 5'd12,
    EV_RETURN      = 5'd13,
    EV_SB_FULL     = 5'd14,
    EV_IF_EMPTY    = 5'd15,
    EV_INT         = 5'd20,
    EV_FP          = 5'd21,
    EV_STALL       = 5'd22
  } hpm_event_e;

  typedef enum logic [2:0] {
    FU_NONE, FU_LOAD, FU_STORE, FU_ALU, FU_MULT, FU_CTRL_FLOW, FU_FPU, FU_FPU_VEC
  } fu_e;

  typedef enum logic [1:0] {
    OP_OTHER, OP_ADD, OP_JALR
  } op_e;

  typedef enum logic [2:0] {
    CSR_NONE, CSR_CNT_LO, CSR_CNT_HI, CSR_EVT_SEL, CSR_UCNT_LO, CSR_UCNT_HI
  } csr_kind_e;

  // Slice of a committed instruction seen by event decode
  typedef struct packed {
    fu_e              fu;
    op_e              op;
    logic [REG_W-1:0] rd;
  } commit_instr_t;

  // Single-cycle event pulses from caches, MMU, frontend and issue
  typedef struct packed {
    logic icache_miss;
    logic dcache_miss;
    logic itlb_miss;
    logic dtlb_miss;
    logic exception;
    logic eret;
    logic mispredict;
    logic sb_full;
    logic if_empty;
    logic stall_issue;
  } core_events_t;

  // Counter write request from the CSR file
  typedef struct packed {
    logic              csr_we;  // Any CSR write, stalls counting
    logic              lo_we;
    logic              hi_we;
    logic [IDX_W-1:0]  idx;
    logic [DATA_W-1:0] wdata;
  } cnt_wr_t;

endpackage
